/* files.f */
verilog/scratch_pkg.sv
verilog/write_formatter.sv
verilog/write_arbiter.sv
verilog/scratch_ram.sv
verilog/scratch_top.sv
verif/tb_clock.sv
verif/scratch_props.sv
verif/scratch_tb.sv

/* Makefile */
# Verilator build and run of the scratchpad testbench.

TOP       ?= scratch_tb
FILELIST  ?= files.f
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIMARGS   ?= +verilator+error+limit+1000
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator from $(FILELIST) and run the simulation"
	@echo "  clean  remove the build folder $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "Variables: TOP FILELIST VERILATOR VFLAGS BUILD_DIR SIMARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIMARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* verif/scratch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module scratch_tb;

	localparam int CLK_PERIOD      = 100;
	localparam int DRIVE_DELAY     = 10;
	localparam int RAND_CYCLES     = 300;
	localparam int DIRECTED_CYCLES = 60;  // Reset plus directed tests, rounded up.
	localparam int STIM_CYCLES     = DIRECTED_CYCLES + RAND_CYCLES;

	logic                  clk;
	logic                  rst;
	scratch_pkg::host_wr_t host_a;
	scratch_pkg::host_wr_t host_b;
	scratch_pkg::addr_t    rd_a_addr;
	scratch_pkg::addr_t    rd_b_addr;
	scratch_pkg::word_t    rd_a_data;
	scratch_pkg::word_t    rd_b_data;
	logic                  b_dropped;

	scratch_pkg::word_t ref_mem [scratch_pkg::DEPTH];  // Reference copy of the array.
	scratch_pkg::word_t exp_rd_a;
	scratch_pkg::word_t exp_rd_b;
	logic [31:0]        lfsr;
	int                 errors = 0;
	int                 total;

	tb_clock #(.PERIOD(CLK_PERIOD), .RST_CYCLES(2), .DRIVE_DELAY(DRIVE_DELAY)) clk_i (
		.clk (clk),
		.rst (rst)
	);

	scratch_top dut (
		.clk       (clk),
		.rst       (rst),
		.host_a    (host_a),
		.host_b    (host_b),
		.rd_a_addr (rd_a_addr),
		.rd_b_addr (rd_b_addr),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data),
		.b_dropped (b_dropped)
	);

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// Word after one host command lands on it.
	function automatic scratch_pkg::word_t updated_word(input scratch_pkg::word_t old,
			input scratch_pkg::host_wr_t cmd);
		scratch_pkg::word_t w;
		logic [2:0]         pos;
		w = old;
		case (cmd.op)
			scratch_pkg::OP_WORD: w = cmd.data;
			scratch_pkg::OP_FIELD: begin
				for (int i = 0; i < 4; i++) begin
					pos    = {1'b0, cmd.sel[1:0]} + 3'(i);
					w[pos] = cmd.data[i];
				end
			end
			scratch_pkg::OP_BIT_SET: w[cmd.sel] = 1'b1;
			scratch_pkg::OP_BIT_CLR: w[cmd.sel] = 1'b0;
			default: w = old;
		endcase
		return w;
	endfunction

	function automatic scratch_pkg::host_wr_t make_cmd(input scratch_pkg::wr_op_t op,
			input scratch_pkg::addr_t addr, input scratch_pkg::sel_t sel,
			input scratch_pkg::word_t data);
		scratch_pkg::host_wr_t h;
		h.en   = 1'b1;
		h.op   = op;
		h.addr = addr;
		h.sel  = sel;
		h.data = data;
		return h;
	endfunction

	// Reference model: A wins, reads see the pre-edge words.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < scratch_pkg::DEPTH; i++) begin
				ref_mem[i] <= '0;
			end
			exp_rd_a <= '0;
			exp_rd_b <= '0;
		end else begin
			exp_rd_a <= ref_mem[rd_a_addr];
			exp_rd_b <= ref_mem[rd_b_addr];
			if (host_a.en) begin
				ref_mem[host_a.addr] <= updated_word(ref_mem[host_a.addr], host_a);
			end else if (host_b.en) begin
				ref_mem[host_b.addr] <= updated_word(ref_mem[host_b.addr], host_b);
			end
		end
	end

	a_rd_a: assert property (@(posedge clk) disable iff (rst) rd_a_data == exp_rd_a)
		else begin
			errors++;
			$display("FAILED rd_a_data: expected %h, actual %h",
				$sampled(exp_rd_a), $sampled(rd_a_data));
		end

	a_rd_b: assert property (@(posedge clk) disable iff (rst) rd_b_data == exp_rd_b)
		else begin
			errors++;
			$display("FAILED rd_b_data: expected %h, actual %h",
				$sampled(exp_rd_b), $sampled(rd_b_data));
		end

	task automatic next_cycle();
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic stop_writes();
		host_a.en = 1'b0;
		host_b.en = 1'b0;
	endtask

	task automatic set_reads(input scratch_pkg::addr_t a, input scratch_pkg::addr_t b);
		rd_a_addr = a;
		rd_b_addr = b;
	endtask

	// Watchdog.
	initial begin
		#(longint'(STIM_CYCLES + 20) * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles", STIM_CYCLES + 20);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		host_a    = '0;
		host_b    = '0;
		rd_a_addr = '0;
		rd_b_addr = '0;
		lfsr      = 32'hc3ec;
		wait (rst == 1'b0);

		// Every word reads zero after reset.
		for (int a = 0; a < scratch_pkg::DEPTH; a++) begin
			set_reads(scratch_pkg::addr_t'(a), scratch_pkg::addr_t'(15 - a));
			next_cycle();
		end

		// Word write with a read of the same address on the same edge.
		host_a = make_cmd(scratch_pkg::OP_WORD, 4'h5, 3'd0, 8'ha7);
		set_reads(4'h5, 4'h5);
		next_cycle();
		host_a = make_cmd(scratch_pkg::OP_WORD, 4'h2, 3'd0, 8'h3c);
		next_cycle();
		stop_writes();
		set_reads(4'h2, 4'h5);
		next_cycle();
		next_cycle();

		// Field writes at each offset, then single bits.
		for (int off = 0; off < 4; off++) begin
			host_a = make_cmd(scratch_pkg::OP_FIELD, 4'h2, scratch_pkg::sel_t'(off),
				(off % 2 == 0) ? 8'hfa : 8'h05);
			next_cycle();
		end
		set_reads(4'h3, 4'h3);
		for (int i = 0; i < 8; i++) begin
			host_a = make_cmd(scratch_pkg::OP_BIT_SET, 4'h3, scratch_pkg::sel_t'(i), 8'h00);
			next_cycle();
		end
		for (int i = 0; i < 8; i++) begin
			host_a = make_cmd(scratch_pkg::OP_BIT_CLR, 4'h3, scratch_pkg::sel_t'(i), 8'hff);
			next_cycle();
		end
		stop_writes();
		next_cycle();

		// Collision on one address, then on two, then B alone.
		host_a = make_cmd(scratch_pkg::OP_WORD, 4'h7, 3'd0, 8'h11);
		host_b = make_cmd(scratch_pkg::OP_WORD, 4'h7, 3'd0, 8'h22);
		set_reads(4'h7, 4'h7);
		next_cycle();
		stop_writes();
		next_cycle();
		next_cycle();
		host_a = make_cmd(scratch_pkg::OP_WORD, 4'h8, 3'd0, 8'h33);
		host_b = make_cmd(scratch_pkg::OP_WORD, 4'h9, 3'd0, 8'h44);
		set_reads(4'h8, 4'h9);
		next_cycle();
		stop_writes();
		next_cycle();
		next_cycle();
		host_b = make_cmd(scratch_pkg::OP_FIELD, 4'h9, 3'd2, 8'h0b);
		next_cycle();
		stop_writes();
		next_cycle();
		next_cycle();

		// Random mixed traffic on both ports.
		for (int n = 0; n < RAND_CYCLES; n++) begin
			host_a.en   = rand_bits(1) == 32'd1;
			host_a.op   = scratch_pkg::wr_op_t'(rand_bits(2));
			host_a.addr = scratch_pkg::addr_t'(rand_bits(4));
			host_a.sel  = scratch_pkg::sel_t'(rand_bits(3));
			host_a.data = scratch_pkg::word_t'(rand_bits(8));
			host_b.en   = rand_bits(1) == 32'd1;
			host_b.op   = scratch_pkg::wr_op_t'(rand_bits(2));
			host_b.addr = scratch_pkg::addr_t'(rand_bits(4));
			host_b.sel  = scratch_pkg::sel_t'(rand_bits(3));
			host_b.data = scratch_pkg::word_t'(rand_bits(8));
			set_reads(scratch_pkg::addr_t'(rand_bits(4)), scratch_pkg::addr_t'(rand_bits(4)));
			next_cycle();
		end
		stop_writes();
		next_cycle();
		next_cycle();

		total = errors + dut.props_i.fail_count;
		$display("Errors: %0d read data, %0d property", errors, dut.props_i.fail_count);
		if (total == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/scratch_props.sv */
`timescale 1ns/1ps
`default_nettype none

// Reset and arbitration properties, bound into the top level.
module scratch_props (
	input wire                        clk,
	input wire                        rst,
	input wire scratch_pkg::host_wr_t host_a,
	input wire scratch_pkg::host_wr_t host_b,
	input wire scratch_pkg::word_t    rd_a_data,
	input wire scratch_pkg::word_t    rd_b_data,
	input wire                        b_dropped
);

	int   fail_count = 0;  // Read back at the end of the run.
	logic collide;

	assign collide = host_a.en & host_b.en;

	a_drop_in_reset: assert property (@(posedge clk) rst |-> !b_dropped)
		else begin
			fail_count++;
			$error("b_dropped is high while reset is active");
		end

	// Pulse follows every colliding edge.
	a_drop_after_collide: assert property (@(posedge clk) disable iff (rst)
		collide |=> b_dropped)
		else begin
			fail_count++;
			$error("b_dropped did not pulse after both hosts wrote");
		end

	a_drop_only_after_collide: assert property (@(posedge clk) disable iff (rst)
		!collide |=> !b_dropped)
		else begin
			fail_count++;
			$error("b_dropped is high without a preceding collision");
		end

	a_read_zero_after_reset: assert property (@(posedge clk)
		$fell(rst) |-> (rd_a_data == '0 && rd_b_data == '0))
		else begin
			fail_count++;
			$error("read data is not zero in the first cycle after reset");
		end

endmodule

bind scratch_top scratch_props props_i (
	.clk       (clk),
	.rst       (rst),
	.host_a    (host_a),
	.host_b    (host_b),
	.rd_a_data (rd_a_data),
	.rd_b_data (rd_b_data),
	.b_dropped (b_dropped)
);

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and a reset held for a few cycles.
module tb_clock #(
	parameter int PERIOD      = 100,  // Clock period in ns.
	parameter int RST_CYCLES  = 2,
	parameter int DRIVE_DELAY = 10    // Release point after the edge.
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* verilog/scratch_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Shared scratchpad with two host ports.
// Host A has write priority over host B.
module scratch_top (
	input  wire                         clk,
	input  wire                         rst,
	input  wire scratch_pkg::host_wr_t  host_a,
	input  wire scratch_pkg::host_wr_t  host_b,
	input  wire scratch_pkg::addr_t     rd_a_addr,
	input  wire scratch_pkg::addr_t     rd_b_addr,
	output wire scratch_pkg::word_t     rd_a_data,
	output wire scratch_pkg::word_t     rd_b_data,
	output wire                         b_dropped
);

	// Formatted writes, one per host.
	wire scratch_pkg::mem_wr_t fmt_a;
	wire scratch_pkg::mem_wr_t fmt_b;

	// Winning write into the array.
	wire scratch_pkg::mem_wr_t mem_wr;

	write_formatter fmt_a_i (
		.host (host_a),
		.fmt  (fmt_a)
	);

	write_formatter fmt_b_i (
		.host (host_b),
		.fmt  (fmt_b)
	);

	write_arbiter arb_i (
		.clk       (clk),
		.rst       (rst),
		.fmt_a     (fmt_a),
		.fmt_b     (fmt_b),
		.mem_wr    (mem_wr),
		.b_dropped (b_dropped)
	);

	// Each host reads through its own port.
	scratch_ram ram_i (
		.clk       (clk),
		.rst       (rst),
		.mem_wr    (mem_wr),
		.rd_a_addr (rd_a_addr),
		.rd_b_addr (rd_b_addr),
		.rd_a_data (rd_a_data),
		.rd_b_data (rd_b_data)
	);

endmodule

`default_nettype wire

/* verilog/scratch_ram.sv */
`timescale 1ns/1ps
`default_nettype none

// Scratchpad array: one masked write port, two registered read ports.
module scratch_ram (
	input  wire                        clk,
	input  wire                        rst,
	input  wire scratch_pkg::mem_wr_t  mem_wr,
	input  wire scratch_pkg::addr_t    rd_a_addr,
	input  wire scratch_pkg::addr_t    rd_b_addr,
	output scratch_pkg::word_t         rd_a_data,
	output scratch_pkg::word_t         rd_b_data
);

	scratch_pkg::word_t mem [scratch_pkg::DEPTH];
	scratch_pkg::word_t old_word;    // Current contents at the write address.
	scratch_pkg::word_t merged_word;  // Word after the masked write.

	assign old_word = mem[mem_wr.addr];

	// Merge bit by bit. Unmasked bits keep the stored value.
	always_comb begin
		for (int b = 0; b < scratch_pkg::DATA_W; b++) begin
			if (mem_wr.mask[b]) begin
				merged_word[b] = mem_wr.data[b];
			end else begin
				merged_word[b] = old_word[b];
			end
		end
	end

	// Array update, cleared as a whole on reset.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < scratch_pkg::DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (mem_wr.en) begin
			mem[mem_wr.addr] <= merged_word;
		end
	end

	// Read registers sample the pre-edge contents.
	// A read of the word written on the same edge sees the old value.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_a_data <= '0;
			rd_b_data <= '0;
		end else begin
			rd_a_data <= mem[rd_a_addr];
			rd_b_data <= mem[rd_b_addr];
		end
	end

endmodule

`default_nettype wire

/* verilog/write_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

// Fixed-priority choice between the two formatted writes.
// Port A always wins; a B write in the same cycle is lost.
module write_arbiter (
	input  wire                        clk,
	input  wire                        rst,
	input  wire scratch_pkg::mem_wr_t  fmt_a,
	input  wire scratch_pkg::mem_wr_t  fmt_b,
	output scratch_pkg::mem_wr_t       mem_wr,
	output logic                       b_dropped
);

	logic collide;  // Both ports write this cycle.

	assign collide = fmt_a.en & fmt_b.en;

	// Write port mux.
	// When neither port writes, fmt_b passes with en low.
	always_comb begin
		if (fmt_a.en) begin
			mem_wr = fmt_a;
		end else begin
			mem_wr = fmt_b;
		end
	end

	// One-cycle pulse after each colliding edge.
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			b_dropped <= 1'b0;
		end else begin
			b_dropped <= collide;  // Addresses do not matter.
		end
	end

endmodule

`default_nettype wire

/* verilog/write_formatter.sv */
`timescale 1ns/1ps
`default_nettype none

// Converts one host write command into an aligned word and a per-bit mask.
module write_formatter (
	input  wire scratch_pkg::host_wr_t host,
	output scratch_pkg::mem_wr_t       fmt
);

	logic [1:0]           field_off;   // Field offset, sel modulo 4.
	scratch_pkg::nibble_t field_data;
	scratch_pkg::word_t   field_mask;
	scratch_pkg::word_t   field_word;
	scratch_pkg::word_t   bit_mask;
	scratch_pkg::word_t   fmt_data;
	scratch_pkg::word_t   fmt_mask;

	assign field_off  = host.sel[1:0];
	assign field_data = host.data[3:0];

	// Four ones, shifted into place.
	assign field_mask = {4'h0, 4'hf} << field_off;

	// Payload nibble moved to the same position as the mask.
	assign field_word = {4'h0, field_data} << field_off;

	// Single bit selected by the full three-bit index.
	assign bit_mask = 8'h01 << host.sel;

	always_comb begin
		case (host.op)
			scratch_pkg::OP_WORD: begin
				fmt_mask = '1;         // Every bit written.
				fmt_data = host.data;
			end
			scratch_pkg::OP_FIELD: begin
				fmt_mask = field_mask;
				fmt_data = field_word;
			end
			scratch_pkg::OP_BIT_SET: begin
				fmt_mask = bit_mask;
				fmt_data = '1;  // Only the masked bit lands.
			end
			scratch_pkg::OP_BIT_CLR: begin
				fmt_mask = bit_mask;
				fmt_data = '0;
			end
			default: begin
				fmt_mask = '0;
				fmt_data = '0;
			end
		endcase
	end

	// Enable and address pass straight through.
	always_comb begin
		fmt.en   = host.en;
		fmt.addr = host.addr;
		fmt.data = fmt_data;
		fmt.mask = fmt_mask;
	end

endmodule

`default_nettype wire

/* verilog/scratch_pkg.sv */
`default_nettype none

package scratch_pkg;

	// Memory geometry.
	localparam int ADDR_W = 4;
	localparam int DEPTH  = 16;  // Equals 2**ADDR_W.
	localparam int DATA_W = 8;

	typedef logic [ADDR_W-1:0] addr_t;  // Word address.
	typedef logic [DATA_W-1:0] word_t;  // Data word or per-bit write mask.
	typedef logic [2:0]        sel_t;   // Field offset (low two bits) or bit index.
	typedef logic [3:0]        nibble_t;  // Field write payload.

	// Host write command kinds.
	typedef enum logic [1:0] {
		OP_WORD    = 2'd0,  // Whole word.
		OP_FIELD   = 2'd1,  // Four-bit field at offset sel[1:0].
		OP_BIT_SET = 2'd2,  // Set bit sel.
		OP_BIT_CLR = 2'd3   // Clear bit sel.
	} wr_op_t;

	// One host command, sampled on every edge where en is high.
	typedef struct packed {
		logic   en;
		wr_op_t op;
		addr_t  addr;
		sel_t   sel;
		word_t  data;  // Field writes use data[3:0].
	} host_wr_t;

	// One masked write into the array.
	typedef struct packed {
		logic  en;
		addr_t addr;
		word_t data;
		word_t mask;  // 1 selects the data bit.
	} mem_wr_t;

endpackage

`default_nettype wire
